// ==== logic/zstd_raw_dec_pkg.sv ====
// Raw block decoder package
// Shared widths, beat and output word types, AXI read constants
`default_nettype none

package zstd_raw_dec_pkg;

  localparam int AXI_DATA_W   = 32;
  localparam int AXI_ADDR_W   = 16;
  localparam int AXI_ID_W     = 4;
  localparam int OUTPUT_WIDTH = 97;

  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_ID_W-1:0]   axi_id_t;
  // Beats in the burst minus one
  typedef logic [7:0]            axi_len_t;
  typedef logic [2:0]            beat_bytes_t;
  typedef logic [31:0]           xfer_len_t;
  typedef logic [63:0]           out_data_t;
  // Last flag, byte count, data
  typedef logic [OUTPUT_WIDTH-1:0] out_word_t;

  localparam axi_id_t    READER_ID      = '0;
  localparam logic [2:0] AXI_SIZE_4B    = 3'd2;
  localparam logic [1:0] AXI_BURST_INCR = 2'd1;

endpackage : zstd_raw_dec_pkg

`default_nettype wire

// ==== logic/beat_stream_if.sv ====
// Beat stream between reader, FIFO and packer
// Data word with its valid byte count and a transfer-end flag
`timescale 1ns/100ps
`default_nettype none

interface beat_stream_if;
  import zstd_raw_dec_pkg::*;

  logic        valid;
  axi_data_t   data;
  beat_bytes_t bytes;
  logic        last;
  logic        ready;

  modport source (output valid, output data, output bytes, output last, input ready);

  modport sink (input valid, input data, input bytes, input last, output ready);

endinterface : beat_stream_if

`default_nettype wire

// ==== logic/axi_block_reader.sv ====
// AXI block reader
// Splits a byte range into INCR read bursts and streams the R beats onward
`timescale 1ns/100ps
`default_nettype none

module axi_block_reader #(
  parameter int MAX_BURST  = 16,
  parameter int FIFO_DEPTH = 32
) (
  input  logic                            clk,
  input  logic                            reset,

  input  logic                            start,
  input  zstd_raw_dec_pkg::axi_addr_t     start_addr,
  input  zstd_raw_dec_pkg::xfer_len_t     start_len,
  output logic                            busy,
  input  logic                            done,

  input  logic [$clog2(FIFO_DEPTH+1)-1:0] free_slots,

  output zstd_raw_dec_pkg::axi_id_t       arid,
  output zstd_raw_dec_pkg::axi_addr_t     araddr,
  output zstd_raw_dec_pkg::axi_len_t      arlen,
  output logic [2:0]                      arsize,
  output logic [1:0]                      arburst,
  output logic                            arvalid,
  input  logic                            arready,

  input  zstd_raw_dec_pkg::axi_data_t     rdata,
  input  logic                            rvalid,
  output logic                            rready,

  beat_stream_if.source                   beats
);
  import zstd_raw_dec_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_DATA,
    ST_WAIT_DONE
  } state_t;

  state_t      state;
  axi_addr_t   next_addr;
  xfer_len_t   rem_bytes;
  logic [29:0] rem_beats;
  logic [8:0]  burst_beats;
  logic [8:0]  beats_left;
  logic        space_ok;
  logic        ar_fire;
  logic        beat_take;

  // Burst size is the smaller of MAX_BURST and what is left
  assign rem_beats   = rem_bytes[31:2];
  assign burst_beats = (rem_beats > 30'(MAX_BURST)) ? 9'(MAX_BURST) : rem_beats[8:0];

  // Whole burst must fit in the FIFO before it is requested
  assign space_ok = 32'(free_slots) >= 32'(burst_beats);

  assign arid    = READER_ID;
  assign araddr  = next_addr;
  assign arlen   = axi_len_t'(burst_beats - 9'd1);
  assign arsize  = AXI_SIZE_4B;
  assign arburst = AXI_BURST_INCR;
  assign arvalid = (state == ST_REQUEST) && space_ok;
  assign ar_fire = arvalid && arready;

  assign rready    = (state == ST_DATA) && beats.ready;
  assign beat_take = rvalid && rready;

  assign beats.valid = (state == ST_DATA) && rvalid;
  assign beats.data  = rdata;
  assign beats.bytes = (rem_bytes > 32'd4) ? 3'd4 : rem_bytes[2:0];
  assign beats.last  = (rem_bytes <= 32'd4);

  assign busy = (state != ST_IDLE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_REQUEST;
          end
        end
        ST_REQUEST: begin
          if (ar_fire) begin
            state <= ST_DATA;
          end
        end
        ST_DATA: begin
          // Burst end comes from the beat count
          if (beat_take && beats_left == 9'd1) begin
            state <= beats.last ? ST_WAIT_DONE : ST_REQUEST;
          end
        end
        ST_WAIT_DONE: begin
          if (done) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      next_addr <= start_addr;
      rem_bytes <= start_len;
    end
    if (ar_fire) begin
      next_addr  <= next_addr + axi_addr_t'({burst_beats, 2'b00});
      beats_left <= burst_beats;
    end
    if (beat_take) begin
      rem_bytes  <= rem_bytes - xfer_len_t'(beats.bytes);
      beats_left <= beats_left - 9'd1;
    end
  end

endmodule : axi_block_reader

`default_nettype wire

// ==== logic/beat_fifo.sv ====
// Beat FIFO
// Circular buffer of stream beats, reports free space to the reader
`timescale 1ns/100ps
`default_nettype none

module beat_fifo #(
  parameter int FIFO_DEPTH = 32
) (
  input  logic                            clk,
  input  logic                            reset,
  beat_stream_if.sink                     in_beats,
  beat_stream_if.source                   out_beats,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] free_slots
);
  import zstd_raw_dec_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  axi_data_t        mem_data  [FIFO_DEPTH];
  beat_bytes_t      mem_bytes [FIFO_DEPTH];
  logic             mem_last  [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_beats.ready  = (count != CNT_W'(FIFO_DEPTH));
  assign out_beats.valid = (count != '0);
  assign out_beats.data  = mem_data[rd_ptr];
  assign out_beats.bytes = mem_bytes[rd_ptr];
  assign out_beats.last  = mem_last[rd_ptr];

  assign push = in_beats.valid && in_beats.ready;
  assign pop  = out_beats.valid && out_beats.ready;

  always_comb begin
    case ({push, pop})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      free_slots <= CNT_W'(FIFO_DEPTH);
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count      <= count_next;
      free_slots <= CNT_W'(FIFO_DEPTH) - count_next;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_data[wr_ptr]  <= in_beats.data;
      mem_bytes[wr_ptr] <= in_beats.bytes;
      mem_last[wr_ptr]  <= in_beats.last;
    end
  end

endmodule : beat_fifo

`default_nettype wire

// ==== logic/output_packer.sv ====
// Output packer
// Joins 32-bit beats little-endian into 97-bit output words and signals the end
`timescale 1ns/100ps
`default_nettype none

module output_packer (
  input  logic                        clk,
  input  logic                        reset,

  beat_stream_if.sink                 beats,

  output zstd_raw_dec_pkg::out_word_t output_data,
  output logic                        output_vld,
  input  logic                        output_rdy,

  output logic                        notify_data,
  output logic                        notify_vld,
  input  logic                        notify_rdy,

  output logic                        done
);
  import zstd_raw_dec_pkg::*;

  typedef enum logic [1:0] {
    ST_COLLECT,
    ST_EMIT,
    ST_NOTIFY
  } state_t;

  state_t      state;
  axi_data_t   lo_data;
  beat_bytes_t lo_bytes;
  logic        have_lo;
  logic        take;
  logic        word_done;
  logic        word_last;
  out_data_t   word_data;
  xfer_len_t   word_count;

  assign beats.ready = (state == ST_COLLECT);
  assign take        = beats.valid && beats.ready;
  assign word_done   = take && (have_lo || beats.last);

  // First beat of a word always sits in bytes 0 to 3
  assign word_data  = have_lo ? {beats.data, lo_data} : {32'h0, beats.data};
  assign word_count = have_lo ? xfer_len_t'(lo_bytes) + xfer_len_t'(beats.bytes)
                              : xfer_len_t'(beats.bytes);
  assign word_last  = output_data[OUTPUT_WIDTH-1];

  assign output_vld  = (state == ST_EMIT);
  assign notify_vld  = (state == ST_NOTIFY);
  assign notify_data = notify_vld;
  assign done        = notify_vld && notify_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_COLLECT;
      have_lo <= 1'b0;
    end else begin
      if (take) begin
        have_lo <= !have_lo && !beats.last;
      end
      case (state)
        ST_COLLECT: begin
          if (word_done) begin
            state <= ST_EMIT;
          end
        end
        ST_EMIT: begin
          if (output_rdy) begin
            state <= word_last ? ST_NOTIFY : ST_COLLECT;
          end
        end
        ST_NOTIFY: begin
          if (notify_rdy) begin
            state <= ST_COLLECT;
          end
        end
        default: begin
          state <= ST_COLLECT;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take && !have_lo) begin
      lo_data  <= beats.data;
      lo_bytes <= beats.bytes;
    end
    if (word_done) begin
      output_data <= {beats.last, word_count, word_data};
    end
  end

endmodule : output_packer

`default_nettype wire

// ==== logic/zstd_raw_dec.sv ====
// Raw block decoder top
// Reads a byte range over AXI and emits it as packed 64-bit output words
`timescale 1ns/100ps
`default_nettype none

module zstd_raw_dec #(
  parameter int MAX_BURST  = 16,
  parameter int FIFO_DEPTH = 32
) (
  input  logic                        clk,
  input  logic                        reset,

  input  logic                        start,
  input  zstd_raw_dec_pkg::axi_addr_t start_addr,
  input  zstd_raw_dec_pkg::xfer_len_t start_len,
  output logic                        busy,

  // AXI read address
  output zstd_raw_dec_pkg::axi_id_t   arid,
  output zstd_raw_dec_pkg::axi_addr_t araddr,
  output zstd_raw_dec_pkg::axi_len_t  arlen,
  output logic [2:0]                  arsize,
  output logic [1:0]                  arburst,
  output logic                        arvalid,
  input  logic                        arready,

  // AXI read data, burst end is taken from the beat count
  input  zstd_raw_dec_pkg::axi_data_t rdata,
  input  logic                        rlast,
  input  logic                        rvalid,
  output logic                        rready,

  output zstd_raw_dec_pkg::out_word_t output_data,
  output logic                        output_vld,
  input  logic                        output_rdy,

  output logic                        notify_data,
  output logic                        notify_vld,
  input  logic                        notify_rdy
);

  logic [$clog2(FIFO_DEPTH+1)-1:0] free_slots;
  logic                            done;

  beat_stream_if rd_beats ();
  beat_stream_if fifo_beats ();

  axi_block_reader #(
    .MAX_BURST  (MAX_BURST),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) reader_i (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .start_addr (start_addr),
    .start_len  (start_len),
    .busy       (busy),
    .done       (done),
    .free_slots (free_slots),
    .arid       (arid),
    .araddr     (araddr),
    .arlen      (arlen),
    .arsize     (arsize),
    .arburst    (arburst),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .rready     (rready),
    .beats      (rd_beats.source)
  );

  beat_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo_i (
    .clk        (clk),
    .reset      (reset),
    .in_beats   (rd_beats.sink),
    .out_beats  (fifo_beats.source),
    .free_slots (free_slots)
  );

  output_packer packer_i (
    .clk         (clk),
    .reset       (reset),
    .beats       (fifo_beats.sink),
    .output_data (output_data),
    .output_vld  (output_vld),
    .output_rdy  (output_rdy),
    .notify_data (notify_data),
    .notify_vld  (notify_vld),
    .notify_rdy  (notify_rdy),
    .done        (done)
  );

endmodule : zstd_raw_dec

`default_nettype wire

// ==== verification/axi_mem_model.sv ====
// AXI read slave model
// Byte at address a is (7a + 3) mod 256, with random address and data stalls
`timescale 1ns/100ps
`default_nettype none

module axi_mem_model (
  input  logic                        clk,
  input  logic                        reset,
  input  zstd_raw_dec_pkg::axi_addr_t araddr,
  input  zstd_raw_dec_pkg::axi_len_t  arlen,
  input  logic                        arvalid,
  output logic                        arready,
  output zstd_raw_dec_pkg::axi_data_t rdata,
  output logic                        rlast,
  output logic                        rvalid,
  input  logic                        rready
);
  import zstd_raw_dec_pkg::*;

  localparam int READY_PCT = 70;

  logic       ar_rdy  = 1'b0;
  logic       r_vld   = 1'b0;
  logic       r_last  = 1'b0;
  axi_data_t  r_data  = '0;
  logic       active  = 1'b0;
  axi_addr_t  rd_addr = '0;
  logic [8:0] rd_left = '0;

  function automatic logic [7:0] mem_byte(input axi_addr_t a);
    return 8'((32'(a) * 7 + 3) % 256);
  endfunction

  function automatic axi_data_t mem_word(input axi_addr_t a);
    return {mem_byte(a + 16'd3), mem_byte(a + 16'd2), mem_byte(a + 16'd1), mem_byte(a)};
  endfunction

  assign arready = ar_rdy;
  assign rvalid  = r_vld;
  assign rlast   = r_last;
  assign rdata   = r_data;

  always @(posedge clk) begin
    if (reset) begin
      ar_rdy <= 1'b0;
      r_vld  <= 1'b0;
      r_last <= 1'b0;
      active <= 1'b0;
    end else if (!active) begin
      if (arvalid && ar_rdy) begin
        active  <= 1'b1;
        rd_addr <= araddr;
        rd_left <= {1'b0, arlen} + 9'd1;
        ar_rdy  <= 1'b0;
      end else begin
        ar_rdy <= (int'($urandom_range(99)) < READY_PCT);
      end
    end else if (r_vld && rready) begin
      rd_addr <= rd_addr + 16'd4;
      rd_left <= rd_left - 9'd1;
      r_vld   <= 1'b0;
      if (rd_left == 9'd1) begin
        active <= 1'b0;
      end
    end else if (!r_vld && (int'($urandom_range(99)) < READY_PCT)) begin
      // A presented beat stays until taken
      r_vld  <= 1'b1;
      r_data <= mem_word(rd_addr);
      r_last <= (rd_left == 9'd1);
    end
  end

endmodule : axi_mem_model

`default_nettype wire

// ==== verification/zstd_raw_dec_checker.sv ====
// Port checker for the raw block decoder
// AXI address hold, burst end, output hold and notify exclusion
`timescale 1ns/100ps
`default_nettype none

module zstd_raw_dec_checker (
  input logic                        clk,
  input logic                        reset,
  input zstd_raw_dec_pkg::axi_addr_t araddr,
  input zstd_raw_dec_pkg::axi_len_t  arlen,
  input logic                        arvalid,
  input logic                        arready,
  input logic                        rlast,
  input logic                        rvalid,
  input logic                        rready,
  input zstd_raw_dec_pkg::out_word_t output_data,
  input logic                        output_vld,
  input logic                        output_rdy,
  input logic                        notify_vld
);

  int unsigned fail_count = 0;

  ar_hold: assert property (@(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
    else begin
      $error("arvalid dropped or AR fields changed before arready");
      fail_count++;
    end

  // Reader drops rready right after its own final beat of a burst
  burst_end: assert property (@(posedge clk) disable iff (reset)
    rvalid && rready |=> rready == !$past(rlast))
    else begin
      $error("rlast does not match the final beat of the burst");
      fail_count++;
    end

  out_hold: assert property (@(posedge clk) disable iff (reset)
    output_vld && !output_rdy |=> output_vld && $stable(output_data))
    else begin
      $error("output_vld dropped or output_data changed before output_rdy");
      fail_count++;
    end

  notify_excl: assert property (@(posedge clk) disable iff (reset)
    !(notify_vld && output_vld))
    else begin
      $error("notify_vld high together with output_vld");
      fail_count++;
    end

endmodule : zstd_raw_dec_checker

bind zstd_raw_dec zstd_raw_dec_checker checker_i (
  .clk         (clk),
  .reset       (reset),
  .araddr      (araddr),
  .arlen       (arlen),
  .arvalid     (arvalid),
  .arready     (arready),
  .rlast       (rlast),
  .rvalid      (rvalid),
  .rready      (rready),
  .output_data (output_data),
  .output_vld  (output_vld),
  .output_rdy  (output_rdy),
  .notify_vld  (notify_vld)
);

`default_nettype wire

// ==== verification/zstd_raw_dec_tb.sv ====
// Testbench for the raw block decoder
// Table of transfers against an AXI memory model, word and notify checks
`timescale 1ns/100ps
`default_nettype none

module zstd_raw_dec_tb;
  import zstd_raw_dec_pkg::*;

  typedef struct {
    string     name;
    axi_addr_t addr;
    xfer_len_t len;
    int        stall_pct;
    bit        extra_start;
  } row_t;

  localparam int NUM_ROWS = 6;

  logic      clk        = 1'b0;
  logic      reset;
  logic      start;
  axi_addr_t start_addr;
  xfer_len_t start_len;
  logic      busy;
  axi_id_t   arid;
  axi_addr_t araddr;
  axi_len_t  arlen;
  logic [2:0] arsize;
  logic [1:0] arburst;
  logic      arvalid;
  logic      arready;
  axi_data_t rdata;
  logic      rlast;
  logic      rvalid;
  logic      rready;
  out_word_t output_data;
  logic      output_vld;
  logic      output_rdy = 1'b0;
  logic      notify_data;
  logic      notify_vld;
  logic      notify_rdy;

  row_t      rows [NUM_ROWS];
  out_data_t exp_data [$];
  xfer_len_t exp_count [$];
  logic      exp_last [$];
  string     cur_name  = "reset";
  int        cur_stall = 0;
  int        limit_cycles = 0;
  int        data_errors = 0;
  int        count_errors = 0;
  int        last_errors = 0;
  int        ar_errors = 0;
  int        protocol_errors = 0;

  zstd_raw_dec #(
    .MAX_BURST  (16),
    .FIFO_DEPTH (32)
  ) zstd_raw_dec_i (
    .clk (clk), .reset (reset),
    .start (start), .start_addr (start_addr), .start_len (start_len), .busy (busy),
    .arid (arid), .araddr (araddr), .arlen (arlen), .arsize (arsize),
    .arburst (arburst), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rlast (rlast), .rvalid (rvalid), .rready (rready),
    .output_data (output_data), .output_vld (output_vld), .output_rdy (output_rdy),
    .notify_data (notify_data), .notify_vld (notify_vld), .notify_rdy (notify_rdy)
  );

  axi_mem_model mem_i (
    .clk (clk), .reset (reset),
    .araddr (araddr), .arlen (arlen), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rlast (rlast), .rvalid (rvalid), .rready (rready)
  );

  always #2 clk = ~clk;

  function automatic logic [7:0] mem_byte(input axi_addr_t a);
    logic [31:0] v;
    v = 32'(a) * 32'd7 + 32'd3;
    return v[7:0];
  endfunction

  function automatic int error_total();
    return data_errors + count_errors + last_errors + ar_errors + protocol_errors
           + int'(zstd_raw_dec_i.checker_i.fail_count);
  endfunction

  task automatic compare_data(input string name, input out_data_t exp, input out_data_t act);
    if (act !== exp) begin
      data_errors++;
      $display("ERROR %s: data expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input xfer_len_t exp, input xfer_len_t act);
    if (act !== exp) begin
      count_errors++;
      $display("ERROR %s: byte count expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic verify_last(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      last_errors++;
      $display("ERROR %s: last flag expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic ar_field_check(input string name,
                                input axi_id_t exp_id, input axi_id_t act_id,
                                input logic [2:0] exp_size, input logic [2:0] act_size,
                                input logic [1:0] exp_burst, input logic [1:0] act_burst);
    if (act_id !== exp_id || act_size !== exp_size || act_burst !== exp_burst) begin
      ar_errors++;
      $display("ERROR %s: AR id/size/burst expected %0d/%0d/%0d, actual %0d/%0d/%0d",
               name, exp_id, exp_size, exp_burst, act_id, act_size, act_burst);
    end
  endtask

  task automatic print_counts();
    $display("Errors: data %0d, count %0d, last %0d, ar %0d, protocol %0d, assertion %0d",
             data_errors, count_errors, last_errors, ar_errors, protocol_errors,
             zstd_raw_dec_i.checker_i.fail_count);
  endtask

  // Consecutive 8-byte words from addr, the tail word holds 4 or 8 bytes
  task automatic build_expected(input axi_addr_t addr, input xfer_len_t len);
    xfer_len_t left;
    xfer_len_t n;
    axi_addr_t a;
    out_data_t word;
    int        k;
    left = len;
    a    = addr;
    while (left != 0) begin
      n    = (left > 32'd8) ? 32'd8 : left;
      word = '0;
      for (k = 0; k < int'(n); k++) begin
        word[8*k +: 8] = mem_byte(a + axi_addr_t'(k));
      end
      exp_data.push_back(word);
      exp_count.push_back(n);
      exp_last.push_back(left == n);
      a    = a + 16'd8;
      left = left - n;
    end
  endtask

  task automatic pulse_start(input axi_addr_t addr, input xfer_len_t len);
    @(posedge clk);
    start      <= 1'b1;
    start_addr <= addr;
    start_len  <= len;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic run_row(input int idx);
    int wait_cycles;
    cur_name  = rows[idx].name;
    cur_stall = rows[idx].stall_pct;
    build_expected(rows[idx].addr, rows[idx].len);
    pulse_start(rows[idx].addr, rows[idx].len);
    if (rows[idx].extra_start) begin
      repeat (6) @(posedge clk);
      if (!busy) begin
        protocol_errors++;
        $display("%s: busy is low in the middle of the transfer", cur_name);
      end
      // Must be ignored while busy
      pulse_start(16'h3000, 32'd40);
    end
    while (exp_data.size() != 0) begin
      @(posedge clk);
    end
    wait_cycles = 0;
    while (!notify_vld && wait_cycles < 50) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (!notify_vld) begin
      protocol_errors++;
      $display("%s: notify did not arrive after the last word", cur_name);
    end else begin
      repeat (3) begin
        @(posedge clk);
        if (!notify_vld || !notify_data) begin
          protocol_errors++;
          $display("%s: notify dropped before notify_rdy", cur_name);
        end
      end
      notify_rdy <= 1'b1;
      @(posedge clk);
      notify_rdy <= 1'b0;
      @(posedge clk);
      if (notify_vld || busy) begin
        protocol_errors++;
        $display("%s: notify or busy still high after notify_rdy", cur_name);
      end
    end
    // Quiet gap, stray words show up here
    repeat (8) @(posedge clk);
  endtask

  always @(posedge clk) begin
    output_rdy <= (int'($urandom_range(99)) >= cur_stall);
  end

  always @(posedge clk) begin
    if (!reset && arvalid && arready) begin
      // Fixed ID, 4-byte beats, INCR bursts
      ar_field_check(cur_name, 4'd0, arid, 3'd2, arsize, 2'd1, arburst);
    end
    if (!reset && output_vld && output_rdy) begin
      if (exp_data.size() == 0) begin
        protocol_errors++;
        $display("%s: output word arrived when none was expected", cur_name);
      end else begin
        compare_data(cur_name, exp_data.pop_front(), output_data[63:0]);
        check_count(cur_name, exp_count.pop_front(), output_data[95:64]);
        verify_last(cur_name, exp_last.pop_front(), output_data[96]);
      end
    end
    if (!reset && notify_vld && exp_data.size() != 0) begin
      protocol_errors++;
      $display("%s: notify raised before the last word was accepted", cur_name);
    end
  end

  initial begin
    int total_beats;
    void'($urandom(49263));
    reset      <= 1'b1;
    start      <= 1'b0;
    start_addr <= '0;
    start_len  <= '0;
    notify_rdy <= 1'b0;
    rows[0] = '{"single_word",   16'h0100, 32'd8,   0,  1'b0};
    rows[1] = '{"multi_burst",   16'h0204, 32'd100, 0,  1'b0};
    rows[2] = '{"stalled_256",   16'h1000, 32'd256, 50, 1'b0};
    rows[3] = '{"busy_restart",  16'h0400, 32'd64,  25, 1'b1};
    rows[4] = '{"after_restart", 16'h0604, 32'd4,   0,  1'b0};
    rows[5] = '{"odd_tail",      16'h7ff0, 32'd12,  30, 1'b0};
    total_beats = 0;
    foreach (rows[i]) begin
      total_beats += int'(rows[i].len >> 2);
    end
    limit_cycles = 200 * NUM_ROWS + 40 * total_beats;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    print_counts();
    if (error_total() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles in %s", limit_cycles, cur_name);
    print_counts();
    $display(">>> FAIL");
    $finish;
  end

endmodule : zstd_raw_dec_tb

`default_nettype wire

// ==== zstd_raw_dec.f ====
logic/zstd_raw_dec_pkg.sv
logic/beat_stream_if.sv
logic/axi_block_reader.sv
logic/beat_fifo.sv
logic/output_packer.sv
logic/zstd_raw_dec.sv
verification/axi_mem_model.sv
verification/zstd_raw_dec_checker.sv
verification/zstd_raw_dec_tb.sv

// ==== Makefile ====
# Verilator flow for the raw block decoder

VERILATOR  ?= verilator
TOP        := zstd_raw_dec_tb
FILELIST   := zstd_raw_dec.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --assert -j 0
SIM_ARGS   := +verilator+error+limit+1000
PASS_MSG   := >>> PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
